// ==== sim.f ====
hdl/lsu_pkg.sv
hdl/store_align.sv
hdl/load_extend.sv
hdl/axi_lite_master.sv
hdl/data_ram.sv
hdl/lsu_stage.sv
hdl/lsu_top.sv
tests/lsu_asserts.sv
tests/lsu_tb.sv

// ==== tests/lsu_tb.sv ====
`timescale 1ns/1ns

module lsu_tb;
    import lsu_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int POOL_WORDS = 16;
    localparam int DIRECTED_OPS = 19;
    localparam int RANDOM_OPS = 200;
    localparam int CYCLES_PER_OP = 20;
    localparam int TIMEOUT_CYCLES =
        RESET_CYCLES + (POOL_WORDS + DIRECTED_OPS + RANDOM_OPS) * CYCLES_PER_OP;

    logic              clk;
    logic              rst;
    logic              in_valid;
    logic              in_ready;
    lsu_req_t          in_req;
    logic              out_valid;
    logic              out_ready;
    logic [31:0]       out_result;

    logic [31:0]       rng_state;
    logic [7:0]        shadow [RAM_WORDS*4];
    logic [RAM_AW-1:0] pool [POOL_WORDS];
    int                cycle_count = 0;

    lsu_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_result(out_result)
    );

    bind lsu_stage lsu_asserts lsu_asserts_i (
        .clk       (clk),
        .rst       (rst),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_result(out_result),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
            stop_on_error($sformatf("timeout, run still busy after %0d cycles", cycle_count));
        else if (dut_i.lsu_stage_i.lsu_asserts_i.fail_count != 0)
            stop_on_error("a bound protocol assertion failed");
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    function automatic lsu_req_t make_req(input logic [31:0] addr, input logic [31:0] wdata,
                                          input logic [2:0] f3, input logic rd, input logic wr);
        lsu_req_t r;
        r.addr = addr;
        r.wdata = wdata;
        r.funct3 = f3;
        r.rd_en = rd;
        r.wr_en = wr;
        return r;
    endfunction

    // reference value built from the byte lanes of the shadow memory
    function automatic logic [31:0] expected_load(input logic [RAM_AW-1:0] idx,
                                                  input logic [1:0] off, input logic [2:0] f3);
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] w;
        b = shadow[{idx, off}];
        h = {shadow[{idx, off[1], 1'b1}], shadow[{idx, off[1], 1'b0}]};
        w = {shadow[{idx, 2'd3}], shadow[{idx, 2'd2}], shadow[{idx, 2'd1}], shadow[{idx, 2'd0}]};
        case (f3)
            F3_LB: return {{24{b[7]}}, b};
            F3_LBU: return {24'b0, b};
            F3_LH: return {{16{h[15]}}, h};
            F3_LHU: return {16'b0, h};
            default: return w;
        endcase
    endfunction

    task automatic shadow_store(input logic [RAM_AW-1:0] idx, input logic [1:0] off,
                                input logic [2:0] f3, input logic [31:0] data);
        case (f3)
            F3_SB: shadow[{idx, off}] = data[7:0];
            F3_SH: begin
                shadow[{idx, off[1], 1'b0}] = data[7:0];
                shadow[{idx, off[1], 1'b1}] = data[15:8];
            end
            default: begin
                for (int i = 0; i < 4; i++) begin
                    shadow[{idx, 2'(i)}] = data[8*i +: 8];
                end
            end
        endcase
    endtask

    // starts and ends 1 ns after a rising edge
    task automatic run_op(input lsu_req_t req, input logic [31:0] expected);
        logic        is_mem;
        logic        taken;
        logic [31:0] r;
        is_mem = req.rd_en || req.wr_en;
        taken = 1'b0;
        in_valid = 1'b1;
        in_req = req;
        while (!in_ready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        if (!is_mem) begin
            assert (out_valid)
            else stop_on_error("ALU result not offered one cycle after its input transfer");
        end
        while (!taken) begin
            assert (!in_ready)
            else stop_on_error("stage ready for new input while a result is pending");
            r = next_random();
            out_ready = (r[1:0] != 2'b00);
            if (out_valid && out_ready) begin
                assert (out_result === expected)
                else stop_on_error($sformatf("Mismatch at %0t: result %08h, expected %08h",
                                             $time, out_result, expected));
                taken = 1'b1;
            end
            @(posedge clk);
            #1;
        end
        out_ready = 1'b0;
        assert (!out_valid && in_ready)
        else stop_on_error("result offered again or input not reopened after the transfer");
    endtask

    task automatic alu_op(input logic [31:0] value);
        run_op(make_req(value, next_random(), F3_LW, 1'b0, 1'b0), value);
    endtask

    task automatic store_op(input logic [RAM_AW-1:0] idx, input logic [1:0] off,
                            input logic [2:0] f3, input logic [31:0] data);
        logic [31:0] addr;
        addr = {22'b0, idx, off};
        shadow_store(idx, off, f3, data);
        // stores hand the address back as their result
        run_op(make_req(addr, data, f3, 1'b0, 1'b1), addr);
    endtask

    task automatic load_op(input logic [RAM_AW-1:0] idx, input logic [1:0] off,
                           input logic [2:0] f3);
        run_op(make_req({22'b0, idx, off}, next_random(), f3, 1'b1, 1'b0),
               expected_load(idx, off, f3));
    endtask

    task automatic random_op();
        logic [31:0]       r;
        logic [RAM_AW-1:0] idx;
        logic [1:0]        off;
        int                kind;
        r = next_random();
        idx = pool[r[7:4]];
        off = r[9:8];
        kind = int'(r[31:16] % 16'd9);
        case (kind)
            0: alu_op(next_random());
            1: store_op(idx, 2'd0, F3_SW, next_random());
            2: store_op(idx, {off[1], 1'b0}, F3_SH, next_random());
            3: store_op(idx, off, F3_SB, next_random());
            4: load_op(idx, 2'd0, F3_LW);
            5: load_op(idx, {off[1], 1'b0}, F3_LH);
            6: load_op(idx, {off[1], 1'b0}, F3_LHU);
            7: load_op(idx, off, F3_LB);
            default: load_op(idx, off, F3_LBU);
        endcase
    endtask

    initial begin
        logic [RAM_AW-1:0] idx;
        rng_state = 32'd79938;
        rst = 1'b1;
        in_valid = 1'b0;
        in_req = '0;
        out_ready = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        assert (in_ready && !out_valid)
        else stop_on_error("stage not idle after reset");

        // every pool word gets a full store first so loads see known data
        for (int i = 0; i < POOL_WORDS; i++) begin
            pool[i] = RAM_AW'(next_random());
            store_op(pool[i], 2'd0, F3_SW, next_random());
        end

        alu_op(32'h1234_5678);
        idx = pool[0];
        store_op(idx, 2'd0, F3_SW, 32'hdead_beef);
        load_op(idx, 2'd0, F3_LW);
        store_op(idx, 2'd1, F3_SB, 32'h0000_00a5);
        store_op(idx, 2'd2, F3_SH, 32'h0000_1c3e);
        load_op(idx, 2'd0, F3_LW);

        // both sign polarities in bytes and halfwords
        store_op(idx, 2'd0, F3_SW, 32'h80ff_7f01);
        for (int off = 0; off < 4; off++) begin
            load_op(idx, 2'(off), F3_LB);
            load_op(idx, 2'(off), F3_LBU);
        end
        for (int off = 0; off < 4; off += 2) begin
            load_op(idx, 2'(off), F3_LH);
            load_op(idx, 2'(off), F3_LHU);
        end

        for (int n = 0; n < RANDOM_OPS; n++) begin
            random_op();
        end

        repeat (2) @(posedge clk);
        #1;
        if (dut_i.lsu_stage_i.lsu_asserts_i.fail_count == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            stop_on_error("a bound protocol assertion failed");
        end
    end

endmodule

// ==== tests/lsu_asserts.sv ====
`timescale 1ns/1ns

module lsu_asserts (
    input logic                     clk,
    input logic                     rst,
    input logic                     in_ready,
    input logic                     out_valid,
    input logic                     out_ready,
    input logic [31:0]              out_result,
    input logic [lsu_pkg::XLEN-1:0] awaddr,
    input logic                     awvalid,
    input logic                     awready,
    input logic [lsu_pkg::XLEN-1:0] wdata,
    input logic [3:0]               wstrb,
    input logic                     wvalid,
    input logic                     wready,
    input logic [lsu_pkg::XLEN-1:0] araddr,
    input logic                     arvalid,
    input logic                     arready
);
    // number of failed properties
    int unsigned fail_count = 0;

    out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_result))
    else begin
        $error("out_valid or out_result changed while out_ready was low");
        fail_count++;
    end

    // one instruction in flight
    in_blocked: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> !in_ready)
    else begin
        $error("in_ready high while a result is pending");
        fail_count++;
    end

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr))
    else begin
        $error("awvalid or awaddr changed before awready");
        fail_count++;
    end

    w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
    else begin
        $error("wvalid, wdata or wstrb changed before wready");
        fail_count++;
    end

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
    else begin
        $error("arvalid or araddr changed before arready");
        fail_count++;
    end

endmodule

// ==== hdl/lsu_top.sv ====
`timescale 1ns/1ns

module lsu_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    output logic              in_ready,
    input  lsu_pkg::lsu_req_t in_req,
    output logic              out_valid,
    input  logic              out_ready,
    output logic [31:0]       out_result
);
    import lsu_pkg::*;

    // axi4-lite wires between the stage and the RAM
    logic [XLEN-1:0]   awaddr;
    logic              awvalid;
    logic              awready;
    logic [XLEN-1:0]   wdata;
    logic [STRB_W-1:0] wstrb;
    logic              wvalid;
    logic              wready;
    logic [1:0]        bresp;
    logic              bvalid;
    logic              bready;
    logic [XLEN-1:0]   araddr;
    logic              arvalid;
    logic              arready;
    logic [XLEN-1:0]   rdata;
    logic [1:0]        rresp;
    logic              rvalid;
    logic              rready;

    lsu_stage lsu_stage_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_result(out_result),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready)
    );

    data_ram data_ram_i (
        .clk    (clk),
        .rst    (rst),
        .awaddr (awaddr),
        .awvalid(awvalid),
        .awready(awready),
        .wdata  (wdata),
        .wstrb  (wstrb),
        .wvalid (wvalid),
        .wready (wready),
        .bresp  (bresp),
        .bvalid (bvalid),
        .bready (bready),
        .araddr (araddr),
        .arvalid(arvalid),
        .arready(arready),
        .rdata  (rdata),
        .rresp  (rresp),
        .rvalid (rvalid),
        .rready (rready)
    );

endmodule

// ==== hdl/lsu_stage.sv ====
`timescale 1ns/1ns

module lsu_stage (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  lsu_pkg::lsu_req_t        in_req,
    output logic                     out_valid,
    input  logic                     out_ready,
    output logic [31:0]              out_result,
    output logic [lsu_pkg::XLEN-1:0] awaddr,
    output logic                     awvalid,
    input  logic                     awready,
    output logic [lsu_pkg::XLEN-1:0] wdata,
    output logic [3:0]               wstrb,
    output logic                     wvalid,
    input  logic                     wready,
    input  logic [1:0]               bresp,
    input  logic                     bvalid,
    output logic                     bready,
    output logic [lsu_pkg::XLEN-1:0] araddr,
    output logic                     arvalid,
    input  logic                     arready,
    input  logic [lsu_pkg::XLEN-1:0] rdata,
    input  logic [1:0]               rresp,
    input  logic                     rvalid,
    output logic                     rready
);
    import lsu_pkg::*;

    lsu_req_t        req_q;
    store_lane_t     req_lane;
    logic            in_fire;
    logic            out_fire;
    logic            is_mem;
    logic            start;
    logic            is_write;
    logic [XLEN-1:0] req_addr;
    logic            done;
    logic [XLEN-1:0] rd_word;
    logic [XLEN-1:0] load_value;

    assign in_fire = in_valid && in_ready;
    assign out_fire = out_valid && out_ready;
    assign is_mem = in_req.rd_en || in_req.wr_en;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_ready <= 1'b1;
            out_valid <= 1'b0;
            start <= 1'b0;
        end else begin
            if (in_fire) in_ready <= 1'b0;
            else if (out_fire) in_ready <= 1'b1;
            // alu results are ready at once, memory ops wait for the bus
            if (out_fire) out_valid <= 1'b0;
            else if (in_fire && !is_mem) out_valid <= 1'b1;
            else if (done) out_valid <= 1'b1;
            start <= in_fire && is_mem;
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) req_q <= in_req;
    end

    assign is_write = req_q.wr_en;
    assign req_addr = req_q.addr;

    store_align store_align_i (
        .addr_lo(req_q.addr[1:0]),
        .funct3 (req_q.funct3),
        .src    (req_q.wdata),
        .lane   (req_lane)
    );

    load_extend load_extend_i (
        .addr_lo(req_q.addr[1:0]),
        .funct3 (req_q.funct3),
        .word   (rd_word),
        .value  (load_value)
    );

    // rd_word and req_q only change with the next instruction, so this holds
    assign out_result = req_q.rd_en ? load_value : req_q.addr;

    axi_lite_master axi_lite_master_i (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .is_write (is_write),
        .addr     (req_addr),
        .lane     (req_lane),
        .done     (done),
        .rdata_out(rd_word),
        .awaddr   (awaddr),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .wvalid   (wvalid),
        .wready   (wready),
        .bresp    (bresp),
        .bvalid   (bvalid),
        .bready   (bready),
        .araddr   (araddr),
        .arvalid  (arvalid),
        .arready  (arready),
        .rdata    (rdata),
        .rresp    (rresp),
        .rvalid   (rvalid),
        .rready   (rready)
    );

endmodule

// ==== hdl/data_ram.sv ====
`timescale 1ns/1ns

module data_ram (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [lsu_pkg::XLEN-1:0] awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [lsu_pkg::XLEN-1:0] wdata,
    input  logic [3:0]               wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    output logic [1:0]               bresp,
    output logic                     bvalid,
    input  logic                     bready,
    input  logic [lsu_pkg::XLEN-1:0] araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output logic [lsu_pkg::XLEN-1:0] rdata,
    output logic [1:0]               rresp,
    output logic                     rvalid,
    input  logic                     rready
);
    import lsu_pkg::*;

    logic [XLEN-1:0]   mem [RAM_WORDS];

    logic              aw_full;
    logic              w_full;
    logic [RAM_AW-1:0] aw_idx_q;
    logic [XLEN-1:0]   w_data_q;
    logic [STRB_W-1:0] w_strb_q;
    logic              aw_fire;
    logic              w_fire;
    logic              do_write;
    logic [RAM_AW-1:0] wr_idx;
    logic [XLEN-1:0]   wr_data;
    logic [STRB_W-1:0] wr_strb;

    // no new address or data until the pending response is taken
    assign awready = !aw_full && !bvalid;
    assign wready = !w_full && !bvalid;
    assign arready = !rvalid;
    assign bresp = RESP_OKAY;
    assign rresp = RESP_OKAY;

    assign aw_fire = awvalid && awready;
    assign w_fire = wvalid && wready;
    assign do_write = (aw_full || aw_fire) && (w_full || w_fire);

    // a half that arrives this cycle bypasses its holding register
    assign wr_idx = aw_full ? aw_idx_q : awaddr[RAM_AW+1:2];
    assign wr_data = w_full ? w_data_q : wdata;
    assign wr_strb = w_full ? w_strb_q : wstrb;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            aw_full <= 1'b0;
            w_full <= 1'b0;
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (do_write) begin
                aw_full <= 1'b0;
                w_full <= 1'b0;
            end else begin
                if (aw_fire) aw_full <= 1'b1;
                if (w_fire) w_full <= 1'b1;
            end
            if (do_write) bvalid <= 1'b1;
            else if (bready) bvalid <= 1'b0;
            if (arvalid && arready) rvalid <= 1'b1;
            else if (rready) rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) aw_idx_q <= awaddr[RAM_AW+1:2];
        if (w_fire) begin
            w_data_q <= wdata;
            w_strb_q <= wstrb;
        end
        if (do_write) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (wr_strb[i]) mem[wr_idx][8*i +: 8] <= wr_data[8*i +: 8];
            end
        end
        if (arvalid && arready) rdata <= mem[araddr[RAM_AW+1:2]];
    end

endmodule

// ==== hdl/axi_lite_master.sv ====
`timescale 1ns/1ns

module axi_lite_master (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  logic                     is_write,
    input  logic [lsu_pkg::XLEN-1:0] addr,
    input  lsu_pkg::store_lane_t     lane,
    output logic                     done,
    output logic [lsu_pkg::XLEN-1:0] rdata_out,
    output logic [lsu_pkg::XLEN-1:0] awaddr,
    output logic                     awvalid,
    input  logic                     awready,
    output logic [lsu_pkg::XLEN-1:0] wdata,
    output logic [3:0]               wstrb,
    output logic                     wvalid,
    input  logic                     wready,
    input  logic [1:0]               bresp,
    input  logic                     bvalid,
    output logic                     bready,
    output logic [lsu_pkg::XLEN-1:0] araddr,
    output logic                     arvalid,
    input  logic                     arready,
    input  logic [lsu_pkg::XLEN-1:0] rdata,
    input  logic [1:0]               rresp,
    input  logic                     rvalid,
    output logic                     rready
);
    import lsu_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_RESP
    } state_t;

    state_t state;
    logic   write_q;
    logic   aw_left;
    logic   w_left;
    logic   ar_left;
    logic   b_fire;
    logic   r_fire;

    // a request channel is still open if its valid has not met its ready
    assign aw_left = awvalid && !awready;
    assign w_left = wvalid && !wready;
    assign ar_left = arvalid && !arready;

    assign bready = (state == ST_RESP) && write_q;
    assign rready = (state == ST_RESP) && !write_q;
    assign b_fire = bvalid && bready;
    assign r_fire = rvalid && rready;
    assign done = b_fire || r_fire;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
            write_q <= 1'b0;
            awvalid <= 1'b0;
            wvalid <= 1'b0;
            arvalid <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        write_q <= is_write;
                        awvalid <= is_write;
                        wvalid <= is_write;
                        arvalid <= !is_write;
                        state <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    // aw and w may complete in different cycles
                    if (awready) awvalid <= 1'b0;
                    if (wready) wvalid <= 1'b0;
                    if (arready) arvalid <= 1'b0;
                    if (!aw_left && !w_left && !ar_left) state <= ST_RESP;
                end
                ST_RESP: begin
                    if (done) state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && start) begin
            awaddr <= addr;
            araddr <= addr;
            wdata <= lane.data;
            wstrb <= lane.strb;
        end
        if (r_fire) rdata_out <= (rresp == RESP_OKAY) ? rdata : '0;
    end

endmodule

// ==== hdl/load_extend.sv ====
`timescale 1ns/1ns

module load_extend (
    input  logic [1:0]         addr_lo,
    input  logic [2:0]         funct3,
    input  lsu_pkg::mem_word_u word,
    output logic [31:0]        value
);
    import lsu_pkg::*;

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    // byte view for byte loads, halfword view for halfword loads
    assign byte_sel = word.b[addr_lo];
    assign half_sel = word.h[addr_lo[1]];

    always_comb begin
        case (funct3)
            F3_LB: begin
                value = {{24{byte_sel[7]}}, byte_sel};
            end
            F3_LBU: begin
                value = {24'b0, byte_sel};
            end
            F3_LH: begin
                value = {{16{half_sel[15]}}, half_sel};
            end
            F3_LHU: begin
                value = {16'b0, half_sel};
            end
            F3_LW: begin
                value = word;
            end
            default: begin
                // undefined load code, hand back the raw word
                value = word;
            end
        endcase
    end

endmodule

// ==== hdl/store_align.sv ====
`timescale 1ns/1ns

module store_align (
    input  logic [1:0]           addr_lo,
    input  logic [2:0]           funct3,
    input  logic [31:0]          src,
    output lsu_pkg::store_lane_t lane
);
    import lsu_pkg::*;

    mem_word_u         word;
    logic [STRB_W-1:0] strb;

    // every lane gets a copy, the strobes pick the one that lands
    always_comb begin
        word = '0;
        strb = '0;
        case (funct3)
            F3_SB: begin
                for (int i = 0; i < 4; i++) begin
                    word.b[i] = src[7:0];
                end
                strb = 4'b0001 << addr_lo;
            end
            F3_SH: begin
                for (int i = 0; i < 4; i++) begin
                    word.b[i] = (i % 2 == 1) ? src[15:8] : src[7:0];
                end
                strb = 4'b0011 << {addr_lo[1], 1'b0};
            end
            F3_SW: begin
                for (int i = 0; i < 4; i++) begin
                    word.b[i] = src[8*i +: 8];
                end
                strb = 4'b1111;
            end
            default: begin
                word = '0;
                strb = '0;
            end
        endcase
    end

    assign lane.data = word;
    assign lane.strb = strb;

endmodule

// ==== hdl/lsu_pkg.sv ====
package lsu_pkg;

    // data path and address width
    localparam int XLEN = 32;
    localparam int STRB_W = XLEN / 8;

    // on-chip data RAM geometry
    localparam int RAM_WORDS = 256;
    localparam int RAM_AW = 8;

    // AXI response code, the RAM never reports an error
    localparam logic [1:0] RESP_OKAY = 2'b00;

    // load funct3 encodings
    localparam logic [2:0] F3_LB = 3'b000;
    localparam logic [2:0] F3_LH = 3'b001;
    localparam logic [2:0] F3_LW = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    // store funct3 encodings
    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;

    // memory fields of one instruction as handed over by the execute stage
    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic [2:0]      funct3;
        logic            rd_en;
        logic            wr_en;
    } lsu_req_t;

    // write word already shifted into its byte lanes
    typedef struct packed {
        logic [XLEN-1:0]   data;
        logic [STRB_W-1:0] strb;
    } store_lane_t;

    // one memory word, seen as bytes or as halfwords
    typedef union packed {
        logic [3:0][7:0]  b;
        logic [1:0][15:0] h;
    } mem_word_u;

endpackage
